// File: hdl/epu_defines.svh
`ifndef EPU_DEFINES_SVH
`define EPU_DEFINES_SVH

// frame geometry in luma pixels
// both sides must be multiples of 16
`define FRAME_WIDTH  32
`define FRAME_HEIGHT 32

// macroblocks across one row, minus one
// compared against the column index when stepping raster order
`define WIDTH_MB_NUM_MINUS1 ((`FRAME_WIDTH >> 4) - 1)

// number of macroblock rows in the frame
// the row index reaching this value means the frame is done
`define HEIGHT_MB_NUM (`FRAME_HEIGHT >> 4)

// 32-bit words per luma macroblock
// 16 rows of four words, four pixels per word
`define MB_WORDS 64

`endif

// File: hdl/epu_pkg.sv
`default_nettype none

package epu_pkg;

    // one 8-bit luma sample
    typedef logic [7:0] pixel_t;

    // pixel minus DC, range -255..255
    typedef logic signed [8:0] residual_t;

    // macroblock column or row index
    typedef logic [5:0] mb_coord_t;

    // one macroblock row, element k is the pixel at x = k
    typedef pixel_t [15:0] pixel_row_t;

    // residuals of one row, same ordering as pixel_row_t
    typedef residual_t [15:0] residual_row_t;

    // fetch FSM
    // IDLE requests, LD_Y collects words, WAITINTRA holds the block
    typedef enum logic [1:0] {
        IDLE,
        LD_Y,
        WAITINTRA
    } fetch_state_t;

endpackage : epu_pkg

`default_nettype wire

// File: hdl/mb_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "epu_defines.svh"

module mb_fetch (
    input  wire  logic                clk,
    input  wire  logic                rst,
    input  wire  logic                intra_ready_i,
    input  wire  logic [31:0]         data_word_i,
    input  wire  logic                data_valid_i,
    output logic                      fetch_req_o,
    output logic                      fetch_valid_o,
    output epu_pkg::mb_coord_t        fetch_mb_x_o,
    output epu_pkg::mb_coord_t        fetch_mb_y_o,
    output epu_pkg::pixel_row_t       matrix_y_o [16],
    output logic [31:0]               fetch_addr_o,
    output logic                      frame_done_o
);
    import epu_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;

    // write position inside the macroblock
    logic [3:0] pos_x;
    logic [3:0] pos_y;
    logic [5:0] word_cnt;

    // one word taken from memory this cycle
    logic       word_accept;
    // 64th word of the macroblock
    logic       load_last;
    // engine hands the block back
    logic       release_mb;
    logic       last_col;

    assign word_accept = (state == LD_Y) && data_valid_i;
    assign load_last   = word_accept && (word_cnt == 6'(`MB_WORDS - 1));
    assign release_mb  = (state == WAITINTRA) && intra_ready_i && fetch_valid_o;
    assign last_col    = (fetch_mb_x_o == mb_coord_t'(`WIDTH_MB_NUM_MINUS1));

    // request level only while idle and rows remain
    assign fetch_req_o = (state == IDLE) &&
                         (fetch_mb_y_o != mb_coord_t'(`HEIGHT_MB_NUM));

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (fetch_req_o) next_state = LD_Y;
            LD_Y:      if (load_last) next_state = WAITINTRA;
            WAITINTRA: if (release_mb) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // level towards the engine, up one cycle after the last word
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid_o <= 1'b0;
        end else if (load_last) begin
            fetch_valid_o <= 1'b1;
        end else if (release_mb) begin
            fetch_valid_o <= 1'b0;
        end
    end

    // four pixels per word, so x steps by 4 and y steps after x = 12
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_x    <= 4'd0;
            pos_y    <= 4'd0;
            word_cnt <= 6'd0;
        end else if (load_last) begin
            pos_x    <= 4'd0;
            pos_y    <= 4'd0;
            word_cnt <= 6'd0;
        end else if (word_accept) begin
            pos_x    <= pos_x + 4'd4;
            word_cnt <= word_cnt + 6'd1;
            if (pos_x == 4'd12) begin
                pos_y <= pos_y + 4'd1;
            end
        end
    end

    // address keeps running across macroblocks
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_addr_o <= 32'd0;
        end else if (word_accept) begin
            fetch_addr_o <= fetch_addr_o + 32'd1;
        end
    end

    // raster stepping on release
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_mb_x_o <= '0;
            fetch_mb_y_o <= '0;
            frame_done_o <= 1'b0;
        end else if (release_mb) begin
            if (last_col) begin
                fetch_mb_x_o <= '0;
                fetch_mb_y_o <= fetch_mb_y_o + 6'd1;
                // last row leaves the frame, sticky until reset
                if (fetch_mb_y_o == mb_coord_t'(`HEIGHT_MB_NUM - 1)) begin
                    frame_done_o <= 1'b1;
                end
            end else begin
                fetch_mb_x_o <= fetch_mb_x_o + 6'd1;
            end
        end
    end

    // low byte is the pixel of lowest x
    always_ff @(posedge clk) begin
        if (word_accept) begin
            for (int k = 0; k < 4; k++) begin
                matrix_y_o[pos_y][pos_x + 4'(k)] <= data_word_i[8*k +: 8];
            end
        end
    end

endmodule : mb_fetch

`default_nettype wire

// File: hdl/mb_dc_residual.sv
`timescale 1ns/100ps
`default_nettype none

module mb_dc_residual (
    input  wire  logic                clk,
    input  wire  logic                rst,
    input  wire  logic                fetch_valid_i,
    input  wire  epu_pkg::pixel_row_t matrix_y_i [16],
    input  wire  logic                busy_i,
    output logic                      intra_ready_o,
    output logic                      row_valid_o,
    output logic                      row_last_o,
    output epu_pkg::residual_row_t    row_res_o,
    output epu_pkg::pixel_t           dc_o
);
    import epu_pkg::*;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_SUM,
        ENG_ROUND,
        ENG_ISSUE,
        ENG_DRAIN
    } eng_state_t;

    eng_state_t    state;
    // row being summed, later row being issued
    logic [3:0]    row_idx;
    // max 256 * 255 plus 128 still fits 16 bits
    logic [15:0]   total;
    logic [15:0]   total_rnd;
    logic [11:0]   cur_row_sum;
    residual_row_t cur_res;
    logic          issue;

    function automatic logic [11:0] row_sum(input pixel_row_t row);
        logic [11:0] acc;
        acc = '0;
        for (int k = 0; k < 16; k++) begin
            acc = acc + 12'(row[k]);
        end
        return acc;
    endfunction

    assign cur_row_sum = row_sum(matrix_y_i[row_idx]);
    // round to nearest before dividing by 256
    assign total_rnd   = total + 16'd128;

    // pixel minus DC for the current row, both zero-extended
    always_comb begin
        for (int k = 0; k < 16; k++) begin
            cur_res[k] = $signed({1'b0, matrix_y_i[row_idx][k]}) - $signed({1'b0, dc_o});
        end
    end

    // one row per free serializer slot
    // row_valid_o blocks the cycle before busy comes up
    assign issue = (state == ENG_ISSUE) && !busy_i && !row_valid_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ENG_IDLE;
            row_idx       <= 4'd0;
            total         <= 16'd0;
            intra_ready_o <= 1'b0;
            row_valid_o   <= 1'b0;
            row_last_o    <= 1'b0;
        end else begin
            intra_ready_o <= 1'b0;
            row_valid_o   <= issue;
            row_last_o    <= issue && (row_idx == 4'd15);
            case (state)
                ENG_IDLE: begin
                    // skip the cycle where the old block is still being released
                    if (fetch_valid_i && !intra_ready_o) begin
                        total   <= 16'(cur_row_sum);
                        row_idx <= 4'd1;
                        state   <= ENG_SUM;
                    end
                end
                ENG_SUM: begin
                    total   <= total + 16'(cur_row_sum);
                    row_idx <= row_idx + 4'd1;
                    if (row_idx == 4'd15) begin
                        state <= ENG_ROUND;
                    end
                end
                ENG_ROUND: begin
                    state <= ENG_ISSUE;
                end
                ENG_ISSUE: begin
                    if (issue) begin
                        row_idx <= row_idx + 4'd1;
                        if (row_idx == 4'd15) begin
                            state <= ENG_DRAIN;
                        end
                    end
                end
                ENG_DRAIN: begin
                    // last row counts as taken once busy drops again
                    // strobe still up means busy has not risen for it yet
                    if (!busy_i && !row_valid_o) begin
                        intra_ready_o <= 1'b1;
                        state         <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // DC stays put until the next block is rounded
    always_ff @(posedge clk) begin
        if (state == ENG_ROUND) begin
            dc_o <= total_rnd[15:8];
        end
        if (issue) begin
            row_res_o <= cur_res;
        end
    end

endmodule : mb_dc_residual

`default_nettype wire

// File: hdl/residual_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module residual_serializer (
    input  wire  logic                   clk,
    input  wire  logic                   rst,
    input  wire  logic                   row_valid_i,
    input  wire  logic                   row_last_i,
    input  wire  epu_pkg::residual_row_t row_res_i,
    output logic                         busy_o,
    output logic                         res_valid_o,
    output logic                         res_last_o,
    output epu_pkg::residual_t           res_data_o
);
    import epu_pkg::*;

    // remaining samples, element 0 goes out next
    residual_row_t shreg;
    logic [3:0]    col;
    // row carries the final samples of the macroblock
    logic          last_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_o      <= 1'b0;
            res_valid_o <= 1'b0;
            res_last_o  <= 1'b0;
            col         <= 4'd0;
            last_row    <= 1'b0;
        end else if (row_valid_i) begin
            // sample 0 appears the cycle after the strobe
            busy_o      <= 1'b1;
            res_valid_o <= 1'b1;
            res_last_o  <= 1'b0;
            col         <= 4'd0;
            last_row    <= row_last_i;
        end else if (busy_o) begin
            if (col == 4'd15) begin
                busy_o      <= 1'b0;
                res_valid_o <= 1'b0;
                res_last_o  <= 1'b0;
            end else begin
                col        <= col + 4'd1;
                // flag goes up with column 15
                res_last_o <= last_row && (col == 4'd14);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid_i) begin
            res_data_o <= row_res_i[0];
            shreg      <= row_res_i >> $bits(residual_t);
        end else if (busy_o) begin
            res_data_o <= shreg[0];
            shreg      <= shreg >> $bits(residual_t);
        end
    end

endmodule : residual_serializer

`default_nettype wire

// File: hdl/epu_top.sv
`timescale 1ns/100ps
`default_nettype none

module epu_top (
    input  wire  logic          clk,
    input  wire  logic          rst,
    input  wire  logic [31:0]   data_word_i,
    input  wire  logic          data_valid_i,
    output logic                fetch_req_o,
    output logic [31:0]         fetch_addr_o,
    output logic                res_valid_o,
    output epu_pkg::residual_t  res_data_o,
    output logic                res_last_o,
    output epu_pkg::pixel_t     dc_o,
    output epu_pkg::mb_coord_t  mb_x_o,
    output epu_pkg::mb_coord_t  mb_y_o,
    output logic                frame_done_o
);
    import epu_pkg::*;

    // fetch to engine
    logic          fetch_valid;
    logic          intra_ready;
    pixel_row_t    matrix_y [16];
    // engine to serializer
    logic          row_valid;
    logic          row_last;
    residual_row_t row_res;
    logic          busy;

    // coordinates advance only after res_last_o, so they tag the output directly
    mb_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .intra_ready_i (intra_ready),
        .data_word_i   (data_word_i),
        .data_valid_i  (data_valid_i),
        .fetch_req_o   (fetch_req_o),
        .fetch_valid_o (fetch_valid),
        .fetch_mb_x_o  (mb_x_o),
        .fetch_mb_y_o  (mb_y_o),
        .matrix_y_o    (matrix_y),
        .fetch_addr_o  (fetch_addr_o),
        .frame_done_o  (frame_done_o)
    );

    mb_dc_residual u_dc_residual (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid),
        .matrix_y_i    (matrix_y),
        .busy_i        (busy),
        .intra_ready_o (intra_ready),
        .row_valid_o   (row_valid),
        .row_last_o    (row_last),
        .row_res_o     (row_res),
        .dc_o          (dc_o)
    );

    residual_serializer u_serializer (
        .clk         (clk),
        .rst         (rst),
        .row_valid_i (row_valid),
        .row_last_i  (row_last),
        .row_res_i   (row_res),
        .busy_o      (busy),
        .res_valid_o (res_valid_o),
        .res_last_o  (res_last_o),
        .res_data_o  (res_data_o)
    );

endmodule : epu_top

`default_nettype wire

// File: bench/epu_props.sv
`timescale 1ns/100ps
`default_nettype none

module epu_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic res_valid_i,
    input wire logic res_last_i,
    input wire logic fetch_req_i,
    input wire logic frame_done_i,
    input wire logic intra_ready_i
);

    // last tag only rides on a valid sample
    last_needs_valid: assert property (
        @(posedge clk) disable iff (rst) res_last_i |-> res_valid_i
    ) else $error("res_last_o high without res_valid_o");

    // finished frame, no more requests to memory
    no_req_after_done: assert property (
        @(posedge clk) disable iff (rst) frame_done_i |-> !fetch_req_i
    ) else $error("fetch_req_o high while frame_done_o is set");

    // release from the engine is a single-cycle pulse
    intra_ready_pulse: assert property (
        @(posedge clk) disable iff (rst) intra_ready_i |=> !intra_ready_i
    ) else $error("intra_ready held longer than one cycle");

endmodule : epu_props

`default_nettype wire

// File: bench/epu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "epu_defines.svh"

module epu_tb;
    import epu_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_MB       = (`WIDTH_MB_NUM_MINUS1 + 1) * `HEIGHT_MB_NUM;
    localparam int MB_WORDS     = `MB_WORDS;
    localparam int MEM_WORDS    = NUM_MB * MB_WORDS;
    // per macroblock, fetch with gaps plus the output stretch
    localparam int TIMEOUT_NS   = NUM_MB * (MB_WORDS * 4 + 300) * CLK_PERIOD;
    // drain and release after the final sample
    localparam int DONE_LIMIT   = 20;
    localparam int QUIET_CYCLES = 100;

    typedef enum logic [1:0] {PAT_CONST, PAT_HRAMP, PAT_SAT, PAT_CHECK} pattern_t;

    typedef struct packed {
        pattern_t  kind;
        pixel_t    base;
        mb_coord_t mb_x;
        mb_coord_t mb_y;
        pixel_t    dc;
    } mb_entry_t;

    // one entry per macroblock of the 32x32 frame, raster order
    // dc column is the rounded mean of the 256 pixels
    mb_entry_t stim [NUM_MB] = '{
        '{PAT_CONST, 8'd100, 6'd0, 6'd0, 8'd100},
        // 3 + 8x, mean exactly 63
        '{PAT_HRAMP, 8'd3,   6'd1, 6'd0, 8'd63},
        // 255 with 254 on the diagonal, mean 254.94 rounds up
        '{PAT_SAT,   8'd254, 6'd0, 6'd1, 8'd255},
        // 0 and 255, mean 127.5 rounds up
        '{PAT_CHECK, 8'd0,   6'd1, 6'd1, 8'd128}
    };

    logic        clk;
    logic        rst;
    logic [31:0] data_word;
    logic        data_valid;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        res_valid;
    residual_t   res_data;
    logic        res_last;
    pixel_t      dc;
    mb_coord_t   mb_x;
    mb_coord_t   mb_y;
    logic        frame_done;

    logic [31:0] mem [MEM_WORDS];
    integer      seed = 32'h6e6e_47f8;
    int          error_count = 0;
    int          words_served = 0;

    epu_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .data_word_i  (data_word),
        .data_valid_i (data_valid),
        .fetch_req_o  (fetch_req),
        .fetch_addr_o (fetch_addr),
        .res_valid_o  (res_valid),
        .res_data_o   (res_data),
        .res_last_o   (res_last),
        .dc_o         (dc),
        .mb_x_o       (mb_x),
        .mb_y_o       (mb_y),
        .frame_done_o (frame_done)
    );

    bind epu_top epu_props props0 (
        .clk           (clk),
        .rst           (rst),
        .res_valid_i   (res_valid_o),
        .res_last_i    (res_last_o),
        .fetch_req_i   (fetch_req_o),
        .frame_done_i  (frame_done_o),
        .intra_ready_i (intra_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // reference pixel at row y, column x of macroblock t
    function automatic pixel_t pixel_value(input int t, input int y, input int x);
        case (stim[t].kind)
            PAT_CONST: return stim[t].base;
            PAT_HRAMP: return pixel_t'(int'(stim[t].base) + 8 * x);
            PAT_SAT:   return (x == y) ? stim[t].base : 8'hff;
            default:   return ((x + y) % 2 == 1) ? 8'hff : stim[t].base;
        endcase
    endfunction

    function automatic string pattern_name(input pattern_t k);
        case (k)
            PAT_CONST: return "constant";
            PAT_HRAMP: return "ramp";
            PAT_SAT:   return "saturated";
            default:   return "checkerboard";
        endcase
    endfunction

    // word w of a block holds row w/4, pixels 4*(w%4) up, lowest x in the low byte
    task automatic fill_memory();
        int a;
        for (int t = 0; t < NUM_MB; t++) begin
            for (int w = 0; w < MB_WORDS; w++) begin
                a = t * MB_WORDS + w;
                for (int b = 0; b < 4; b++) begin
                    mem[a][8*b +: 8] = pixel_value(t, w / 4, (w % 4) * 4 + b);
                end
            end
        end
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected, input int t, input int n);
        $display("ERROR: %s = 0x%0h, expected 0x%0h (mb %0d, sample %0d)",
                 name, got, expected, t, n);
        error_count++;
    endtask

    // 64 strobes for one request, random gaps between words
    task automatic serve_request();
        int gap;
        for (int w = 0; w < MB_WORDS; w++) begin
            gap = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 1) : 0;
            repeat (gap) begin
                @(posedge clk);
                data_valid <= 1'b0;
            end
            @(posedge clk);
            data_valid <= 1'b1;
            data_word  <= mem[words_served];
            @(negedge clk);
            // address used by the coming accept edge
            assert (fetch_addr == 32'(words_served))
            else flag_mismatch("fetch_addr_o", fetch_addr, 32'(words_served), -1, w);
            words_served++;
        end
        @(posedge clk);
        data_valid <= 1'b0;
    endtask

    // memory model, answers every request level seen outside reset
    initial begin
        data_valid = 1'b0;
        data_word  = 32'd0;
        forever begin
            @(negedge clk);
            if (!rst && fetch_req) begin
                if (words_served + MB_WORDS > MEM_WORDS) begin
                    $display("ERROR: fetch request beyond the end of the frame memory");
                    error_count++;
                end else begin
                    serve_request();
                end
            end
        end
    end

    // collect 256 samples of macroblock t and compare against the model
    task automatic check_macroblock(input int t);
        int        n;
        residual_t exp_res;
        n = 0;
        while (n < 256) begin
            @(negedge clk);
            assert (!(res_last && !res_valid)) else begin
                $display("ERROR: res_last_o high without res_valid_o in mb %0d", t);
                error_count++;
            end
            if (res_valid) begin
                exp_res = residual_t'(int'(pixel_value(t, n / 16, n % 16)) - int'(stim[t].dc));
                assert (res_data == exp_res)
                else flag_mismatch("res_data_o", {23'd0, res_data}, {23'd0, exp_res}, t, n);
                assert (res_last == (n == 255))
                else flag_mismatch("res_last_o", {31'd0, res_last}, {31'd0, n == 255}, t, n);
                assert (dc == stim[t].dc)
                else flag_mismatch("dc_o", {24'd0, dc}, {24'd0, stim[t].dc}, t, n);
                assert (mb_x == stim[t].mb_x)
                else flag_mismatch("mb_x_o", {26'd0, mb_x}, {26'd0, stim[t].mb_x}, t, n);
                assert (mb_y == stim[t].mb_y)
                else flag_mismatch("mb_y_o", {26'd0, mb_y}, {26'd0, stim[t].mb_y}, t, n);
                n++;
            end
        end
    endtask

    task automatic check_frame_end();
        int waited;
        waited = 0;
        while (!frame_done && waited < DONE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (frame_done) else begin
            $display("ERROR: frame_done_o did not rise within %0d cycles", DONE_LIMIT);
            error_count++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (frame_done && !fetch_req && !res_valid) else begin
                $display("ERROR: activity after the end of the frame");
                error_count++;
            end
        end
        assert (words_served == MEM_WORDS && fetch_addr == 32'(MEM_WORDS))
        else flag_mismatch("fetch_addr_o", fetch_addr, 32'(MEM_WORDS), -1, words_served);
    endtask

    initial begin
        int errors_before;
        int tests_run;
        int tests_failed;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        fill_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < NUM_MB; t++) begin
            errors_before = error_count;
            check_macroblock(t);
            tests_run++;
            if (error_count != errors_before) begin
                tests_failed++;
            end
            $display("test %0d: mb (%0d,%0d) %s, dc 0x%h, %0d errors", t, stim[t].mb_x,
                     stim[t].mb_y, pattern_name(stim[t].kind), stim[t].dc,
                     error_count - errors_before);
        end
        errors_before = error_count;
        check_frame_end();
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %0d: frame end, %0d errors", NUM_MB, error_count - errors_before);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the DUT stopped producing output", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule : epu_tb

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/epu_pkg.sv
hdl/mb_fetch.sv
hdl/mb_dc_residual.sv
hdl/residual_serializer.sv
hdl/epu_top.sv
bench/epu_props.sv
bench/epu_tb.sv

// File: Makefile
# Verilator build and run of the epu testbench

VERILATOR ?= verilator
TOP       ?= epu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
